//--- src/frame_merge_pkg.sv
// frame merge package with the widths, FIFO depth and word types shared by the design
package frame_merge_pkg;

    // stream word width
    localparam int DATA_WIDTH = 8;

    // FIFO memory address bits, at least 2 for the gray full test
    localparam int FIFO_ADDR_WIDTH = 5;
    localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_WIDTH;

    // flops per pointer synchronizer
    localparam int SYNC_STAGES = 3;

    // one stream word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // FIFO pointer, extra msb tells wraps apart
    typedef logic [FIFO_ADDR_WIDTH:0] ptr_t;

    // source tag, 0 = port a, 1 = port b
    typedef logic port_id_t;

    localparam port_id_t PORT_A = 1'b0;
    localparam port_id_t PORT_B = 1'b1;

endpackage

//--- src/axis_async_frame_fifo.sv
// asynchronous AXI4-Stream frame FIFO that drops bad and oversize frames
`timescale 1ns/1ps

module axis_async_frame_fifo import frame_merge_pkg::*; (
    // source side
    input  logic  in_clk,
    input  logic  in_rst,
    input  data_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,
    input  logic  in_tlast,
    input  logic  in_tuser,
    // sink side
    input  logic  output_clk,
    input  logic  output_rst,
    output data_t out_tdata,
    output logic  out_tvalid,
    input  logic  out_tready,
    output logic  out_tlast
);

    // binary to gray
    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // gray back to binary, msb first
    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[FIFO_ADDR_WIDTH] = g[FIFO_ADDR_WIDTH];
        for (int k = FIFO_ADDR_WIDTH - 1; k >= 0; k--) begin
            b[k] = b[k+1] ^ g[k];
        end
        return b;
    endfunction

    // word storage, tlast kept next to the data
    logic [DATA_WIDTH:0] mem [FIFO_DEPTH];

    // write domain state
    ptr_t wr_ptr_commit;
    ptr_t wr_ptr_cur;
    ptr_t wr_ptr_gray;
    ptr_t wr_cur_gray;
    ptr_t [SYNC_STAGES-1:0] rd_gray_sync;

    // read domain state
    ptr_t rd_ptr;
    ptr_t rd_ptr_next;
    ptr_t rd_ptr_gray;
    ptr_t [SYNC_STAGES-1:0] wr_gray_sync;
    logic out_tvalid_reg;

    logic full;
    logic full_cur;
    logic empty;
    logic in_accept;
    logic mem_we;
    logic rd_en;

    assign wr_cur_gray = bin2gray(wr_ptr_cur);

    // full: top two gray bits differ, rest equal
    assign full = (wr_cur_gray[FIFO_ADDR_WIDTH] != rd_gray_sync[SYNC_STAGES-1][FIFO_ADDR_WIDTH])
        && (wr_cur_gray[FIFO_ADDR_WIDTH-1] != rd_gray_sync[SYNC_STAGES-1][FIFO_ADDR_WIDTH-1])
        && (wr_cur_gray[FIFO_ADDR_WIDTH-2:0] == rd_gray_sync[SYNC_STAGES-1][FIFO_ADDR_WIDTH-2:0]);

    // current frame already fills the whole buffer
    assign full_cur = (wr_ptr_cur[FIFO_ADDR_WIDTH] != wr_ptr_commit[FIFO_ADDR_WIDTH])
        && (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0] == wr_ptr_commit[FIFO_ADDR_WIDTH-1:0]);

    // oversize frames keep flowing so they can be swallowed to tlast
    assign in_tready = ~full | full_cur;
    assign in_accept = in_tvalid & in_tready;
    assign mem_we = in_accept & ~full_cur;

    // write pointer control
    always_ff @(posedge in_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_ptr_commit <= '0;
            wr_ptr_cur <= '0;
            wr_ptr_gray <= '0;
        end else if (in_accept) begin
            if (in_tlast) begin
                if (in_tuser || full_cur) begin
                    // bad or oversize, rewind
                    wr_ptr_cur <= wr_ptr_commit;
                end else begin
                    // good frame, publish it
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                    wr_ptr_commit <= wr_ptr_cur + 1'b1;
                    wr_ptr_gray <= bin2gray(wr_ptr_cur + 1'b1);
                end
            end else if (!full_cur) begin
                wr_ptr_cur <= wr_ptr_cur + 1'b1;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (mem_we) begin
            mem[wr_ptr_cur[FIFO_ADDR_WIDTH-1:0]] <= {in_tlast, in_tdata};
        end
    end

    // read pointer into write domain
    always_ff @(posedge in_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_gray_sync <= '0;
        end else begin
            rd_gray_sync <= {rd_gray_sync[SYNC_STAGES-2:0], rd_ptr_gray};
        end
    end

    // committed write pointer into read domain
    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            wr_gray_sync <= '0;
        end else begin
            wr_gray_sync <= {wr_gray_sync[SYNC_STAGES-2:0], wr_ptr_gray};
        end
    end

    assign empty = rd_ptr_gray == wr_gray_sync[SYNC_STAGES-1];
    // refill output register when empty or being consumed
    assign rd_en = (out_tready | ~out_tvalid_reg) & ~empty;
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            rd_ptr <= '0;
            rd_ptr_gray <= '0;
            out_tvalid_reg <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr_next;
                rd_ptr_gray <= bin2gray(rd_ptr_next);
            end
            if (out_tready || !out_tvalid_reg) begin
                out_tvalid_reg <= ~empty;
            end
        end
    end

    // output word register
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            {out_tlast, out_tdata} <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    assign out_tvalid = out_tvalid_reg;

    // offered word holds until taken
    assert property (@(posedge output_clk) disable iff (output_rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
        else $error("fifo output changed while stalled");

    // binary distance to synced read pointer stays below depth on every write
    assert property (@(posedge in_clk) disable iff (in_rst)
        mem_we |-> ptr_t'(wr_ptr_cur - gray2bin(rd_gray_sync[SYNC_STAGES-1])) < FIFO_DEPTH)
        else $error("fifo written while full");

endmodule

//--- src/frame_rr_arbiter.sv
// round-robin frame arbiter merging two streams and tagging the source port
`timescale 1ns/1ps

module frame_rr_arbiter import frame_merge_pkg::*; (
    input  logic     output_clk,
    input  logic     output_rst,
    // port a
    input  data_t    a_tdata,
    input  logic     a_tvalid,
    output logic     a_tready,
    input  logic     a_tlast,
    // port b
    input  data_t    b_tdata,
    input  logic     b_tvalid,
    output logic     b_tready,
    input  logic     b_tlast,
    // merged output
    output data_t    out_tdata,
    output logic     out_tvalid,
    input  logic     out_tready,
    output logic     out_tlast,
    output port_id_t out_tid
);

    // held across a frame once its first word has gone
    logic locked;
    // port that moved the most recent word
    port_id_t last_grant;
    port_id_t grant;
    logic xfer;

    // grant select
    always_comb begin
        if (locked) begin
            grant = last_grant;
        end else if (a_tvalid && b_tvalid) begin
            // both waiting so the other port takes its turn
            grant = (last_grant == PORT_A) ? PORT_B : PORT_A;
        end else if (b_tvalid) begin
            grant = PORT_B;
        end else begin
            grant = PORT_A;
        end
    end

    // mux granted stream straight through
    assign out_tvalid = (grant == PORT_B) ? b_tvalid : a_tvalid;
    assign out_tdata = (grant == PORT_B) ? b_tdata : a_tdata;
    assign out_tlast = (grant == PORT_B) ? b_tlast : a_tlast;
    assign out_tid = grant;

    // ready only to the granted side
    assign a_tready = out_tready && (grant == PORT_A);
    assign b_tready = out_tready && (grant == PORT_B);

    assign xfer = out_tvalid & out_tready;

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            locked <= 1'b0;
            // so port a wins the first tie
            last_grant <= PORT_B;
        end else if (xfer) begin
            locked <= ~out_tlast;
            last_grant <= grant;
        end
    end

    // frames never interleave
    assert property (@(posedge output_clk) disable iff (output_rst)
        xfer && !out_tlast |=> out_tid == $past(out_tid))
        else $error("grant moved inside a frame");

    // unlocked grant always lands on a waiting port and never on an idle one
    assert property (@(posedge output_clk) disable iff (output_rst)
        !locked |-> out_tvalid == (a_tvalid || b_tvalid))
        else $error("output valid does not follow the waiting inputs");

endmodule

//--- src/dual_port_frame_merge.sv
// two-port frame merger with per-port clock-crossing FIFOs and a round-robin arbiter
`timescale 1ns/1ps

module dual_port_frame_merge import frame_merge_pkg::*; (
    // port a source
    input  logic     in_clk_a,
    input  logic     in_rst_a,
    input  data_t    a_in_tdata,
    input  logic     a_in_tvalid,
    output logic     a_in_tready,
    input  logic     a_in_tlast,
    input  logic     a_in_tuser,
    // port b source
    input  logic     in_clk_b,
    input  logic     in_rst_b,
    input  data_t    b_in_tdata,
    input  logic     b_in_tvalid,
    output logic     b_in_tready,
    input  logic     b_in_tlast,
    input  logic     b_in_tuser,
    // merged output
    input  logic     output_clk,
    input  logic     output_rst,
    output data_t    out_tdata,
    output logic     out_tvalid,
    input  logic     out_tready,
    output logic     out_tlast,
    output port_id_t out_tid
);

    // fifo to arbiter, output_clk domain
    data_t fifo_a_tdata;
    logic  fifo_a_tvalid;
    logic  fifo_a_tready;
    logic  fifo_a_tlast;
    data_t fifo_b_tdata;
    logic  fifo_b_tvalid;
    logic  fifo_b_tready;
    logic  fifo_b_tlast;

    axis_async_frame_fifo fifo_a (
        .in_clk(in_clk_a), .in_rst(in_rst_a),
        .in_tdata(a_in_tdata), .in_tvalid(a_in_tvalid), .in_tready(a_in_tready),
        .in_tlast(a_in_tlast), .in_tuser(a_in_tuser),
        .output_clk(output_clk), .output_rst(output_rst),
        .out_tdata(fifo_a_tdata), .out_tvalid(fifo_a_tvalid),
        .out_tready(fifo_a_tready), .out_tlast(fifo_a_tlast)
    );

    axis_async_frame_fifo fifo_b (
        .in_clk(in_clk_b), .in_rst(in_rst_b),
        .in_tdata(b_in_tdata), .in_tvalid(b_in_tvalid), .in_tready(b_in_tready),
        .in_tlast(b_in_tlast), .in_tuser(b_in_tuser),
        .output_clk(output_clk), .output_rst(output_rst),
        .out_tdata(fifo_b_tdata), .out_tvalid(fifo_b_tvalid),
        .out_tready(fifo_b_tready), .out_tlast(fifo_b_tlast)
    );

    // whole frames, round-robin
    frame_rr_arbiter arb0 (
        .output_clk(output_clk), .output_rst(output_rst),
        .a_tdata(fifo_a_tdata), .a_tvalid(fifo_a_tvalid),
        .a_tready(fifo_a_tready), .a_tlast(fifo_a_tlast),
        .b_tdata(fifo_b_tdata), .b_tvalid(fifo_b_tvalid),
        .b_tready(fifo_b_tready), .b_tlast(fifo_b_tlast),
        .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tlast(out_tlast), .out_tid(out_tid)
    );

endmodule

//--- include/frame_merge_checks.svh
// frame merge check tasks comparing output words and counting mismatches
`ifndef FRAME_MERGE_CHECKS_SVH
`define FRAME_MERGE_CHECKS_SVH

// mismatches seen so far
int unsigned error_count = 0;
// compares made so far
int unsigned check_count = 0;

task automatic check_data(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t: %s data got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_last(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t: %s tlast got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_id(input port_id_t got, input port_id_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t: %s port tag got %0d expected %0d", $time, what, got, exp);
    end
endtask

`endif

//--- tb/frame_merge_tb.sv
// frame merge testbench driving both source ports and scoreboarding the merged stream
`timescale 1ns/1ps

module frame_merge_tb import frame_merge_pkg::*; ();

    `include "frame_merge_checks.svh"

    // 40 frames x 40 words x 3 cycles per word x 2 slack
    localparam int TIMEOUT_CYCLES = 40 * 40 * 3 * 2;

    logic output_clk = 1'b0;
    logic in_clk_a = 1'b0;
    logic in_clk_b = 1'b0;
    logic output_rst;
    logic in_rst_a;
    logic in_rst_b;
    data_t a_in_tdata;
    logic a_in_tvalid;
    logic a_in_tready;
    logic a_in_tlast;
    logic a_in_tuser;
    data_t b_in_tdata;
    logic b_in_tvalid;
    logic b_in_tready;
    logic b_in_tlast;
    logic b_in_tuser;
    data_t out_tdata;
    logic out_tvalid;
    logic out_tready = 1'b0;
    logic out_tlast;
    port_id_t out_tid;

    // sink stalled (0), always ready (1) or random (2)
    logic [1:0] ready_mode = 2'd0;
    logic [31:0] lfsr = 32'h4f9e;
    // expected {tlast, tdata} words per port
    logic [DATA_WIDTH:0] exp_a[$];
    logic [DATA_WIDTH:0] exp_b[$];
    // source tag of every finished output frame
    port_id_t frame_order[$];
    port_id_t last_port = PORT_B;
    port_id_t frame_tid = PORT_A;
    logic in_frame = 1'b0;
    int unsigned cycle_count = 0;

    always #50 output_clk = ~output_clk;
    always #35 in_clk_a = ~in_clk_a;
    always #65 in_clk_b = ~in_clk_b;

    dual_port_frame_merge dut0 (.*);

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void push_expected(input port_id_t port, input logic [DATA_WIDTH:0] w);
        if (port == PORT_A) exp_a.push_back(w);
        else exp_b.push_back(w);
    endfunction

    function automatic logic port_ready(input port_id_t port);
        return (port == PORT_A) ? a_in_tready : b_in_tready;
    endfunction

    task automatic wait_fall(input port_id_t port);
        if (port == PORT_A) @(negedge in_clk_a);
        else @(negedge in_clk_b);
    endtask

    task automatic wait_rise(input port_id_t port);
        if (port == PORT_A) @(posedge in_clk_a);
        else @(posedge in_clk_b);
    endtask

    task automatic drive_word(input port_id_t port, input logic v, input data_t d,
                              input logic l, input logic u);
        if (port == PORT_A) begin
            a_in_tvalid = v;
            a_in_tdata = d;
            a_in_tlast = l;
            a_in_tuser = u;
        end else begin
            b_in_tvalid = v;
            b_in_tdata = d;
            b_in_tlast = l;
            b_in_tuser = u;
        end
    endtask

    // one frame that is expected only when good and no longer than the buffer
    task automatic send_frame(input port_id_t port, input int len, input logic bad);
        data_t d;
        logic keep;
        keep = !bad && (len <= FIFO_DEPTH);
        for (int i = 0; i < len; i++) begin
            d = data_t'(take_bits(DATA_WIDTH));
            if (keep) push_expected(port, {i == len - 1, d});
            wait_fall(port);
            drive_word(port, 1'b1, d, i == len - 1, bad && (i == len - 1));
            do begin
                wait_rise(port);
            end while (!port_ready(port));
        end
        wait_fall(port);
        drive_word(port, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic send_random(input port_id_t port, input int frames);
        int len;
        logic bad;
        for (int f = 0; f < frames; f++) begin
            len = 1 + int'(take_bits(4));
            // roughly one in four is bad
            bad = (take_bits(2) == 0);
            send_frame(port, len, bad);
        end
    endtask

    // until every expected word has come out
    task automatic wait_drain();
        while (exp_a.size() != 0 || exp_b.size() != 0) @(posedge output_clk);
        repeat (10) @(posedge output_clk);
    endtask

    task automatic test_single_frames();
        ready_mode = 2'd1;
        send_frame(PORT_A, 6, 1'b0);
        wait_drain();
        send_frame(PORT_B, 6, 1'b0);
        wait_drain();
    endtask

    task automatic test_bad_frame();
        send_frame(PORT_A, 5, 1'b1);
        send_frame(PORT_A, 7, 1'b0);
        wait_drain();
    endtask

    task automatic test_oversize_frame();
        send_frame(PORT_B, FIFO_DEPTH + 8, 1'b0);
        send_frame(PORT_B, 9, 1'b0);
        wait_drain();
    endtask

    // three frames a side queued behind a stalled sink
    task automatic test_round_robin();
        port_id_t exp_port;
        ready_mode = 2'd0;
        frame_order.delete();
        exp_port = ~last_port;
        fork
            for (int f = 0; f < 3; f++) send_frame(PORT_A, 3 + int'(take_bits(3)), 1'b0);
            for (int f = 0; f < 3; f++) send_frame(PORT_B, 3 + int'(take_bits(3)), 1'b0);
        join
        repeat (200) @(posedge output_clk);
        ready_mode = 2'd1;
        wait_drain();
        if (frame_order.size() != 6) begin
            error_count++;
            $display("round-robin test saw %0d frames instead of 6", frame_order.size());
        end
        foreach (frame_order[i]) begin
            check_id(frame_order[i], exp_port, "round-robin order");
            exp_port = ~exp_port;
        end
    endtask

    task automatic test_random_traffic();
        ready_mode = 2'd2;
        fork
            send_random(PORT_A, 12);
            send_random(PORT_B, 12);
        join
        wait_drain();
        ready_mode = 2'd1;
    endtask

    // sink ready changes on the falling edge
    always @(negedge output_clk) begin
        case (ready_mode)
            2'd0: out_tready <= 1'b0;
            2'd1: out_tready <= 1'b1;
            default: out_tready <= take_bits(1) == 1;
        endcase
    end

    // scoreboard pops one word per accepted output beat
    always @(posedge output_clk) begin
        logic [DATA_WIDTH:0] exp_word;
        if (!output_rst && out_tvalid && out_tready) begin
            // tag must not move inside a frame
            if (in_frame) check_id(out_tid, frame_tid, "tag inside frame");
            if ((out_tid == PORT_A && exp_a.size() == 0)
                    || (out_tid == PORT_B && exp_b.size() == 0)) begin
                error_count++;
                $display("port %0d sent a word that no expected frame accounts for", out_tid);
            end else begin
                if (out_tid == PORT_A) exp_word = exp_a.pop_front();
                else exp_word = exp_b.pop_front();
                check_data(out_tdata, exp_word[DATA_WIDTH-1:0], "output word");
                check_last(out_tlast, exp_word[DATA_WIDTH], "output word");
            end
            in_frame = !out_tlast;
            frame_tid = out_tid;
            last_port = out_tid;
            if (out_tlast) frame_order.push_back(out_tid);
        end
    end

    always @(posedge output_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d port a and %0d port b words never arrived",
                     cycle_count, exp_a.size(), exp_b.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        drive_word(PORT_A, 1'b0, '0, 1'b0, 1'b0);
        drive_word(PORT_B, 1'b0, '0, 1'b0, 1'b0);
        output_rst = 1'b1;
        in_rst_a = 1'b1;
        in_rst_b = 1'b1;
        repeat (8) @(posedge output_clk);
        @(negedge output_clk);
        output_rst = 1'b0;
        in_rst_a = 1'b0;
        in_rst_b = 1'b0;
        test_single_frames();
        test_bad_frame();
        test_oversize_frame();
        test_round_robin();
        test_random_traffic();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/frame_merge_pkg.sv
src/axis_async_frame_fifo.sv
src/frame_rr_arbiter.sv
src/dual_port_frame_merge.sv
tb/frame_merge_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame merge testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module frame_merge_tb -o frame_merge_sim --Mdir obj_dir > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/frame_merge_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -qx "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
